/* cpu_config.svh */
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Bus widths
`define CPU_DATA_W 8
`define CPU_ADDR_W 16

// First opcode fetch after reset, no vector fetch
`define CPU_RESET_PC 16'h0200

`endif

/* cpu_pkg.sv */
`include "cpu_config.svh"

package cpu_pkg;

    typedef logic [`CPU_DATA_W-1:0] byte_t;
    typedef logic [`CPU_ADDR_W-1:0] addr_t;

    // Cycle within the current instruction
    typedef enum logic [2:0] {
        T0,
        T1,
        T2,
        T3,
        HALT
    } tcu_t;

    // ALU_XFER hands operand A through, used by TAX
    typedef enum logic [2:0] {
        ALU_PASS,
        ALU_ADC,
        ALU_AND,
        ALU_ORA,
        ALU_EOR,
        ALU_INC,
        ALU_XFER
    } alu_op_t;

    typedef enum logic {
        ADDR_PC,
        ADDR_ABS
    } addr_src_t;

    typedef struct packed {
        logic n;
        logic v;
        logic z;
        logic c;
    } status_t;

    typedef struct packed {
        logic      rw;
        logic      sync;
        addr_src_t addr_src;
        logic      pc_inc;
        logic      pc_load;
        logic      lat_lo;
        logic      lat_hi;
        logic      src_x;
        logic      ld_ac;
        logic      ld_x;
        alu_op_t   alu_op;
        logic      set_nz;
        logic      set_cv;
        logic      clr_c;
        logic      set_c;
    } ctrl_t;

endpackage

/* cpu_alu.sv */
`timescale 1ns/1ns
`include "cpu_config.svh"

module cpu_alu (
    input  cpu_pkg::byte_t   i_a,
    input  cpu_pkg::byte_t   i_b,
    input  logic             i_carry,
    input  cpu_pkg::alu_op_t i_op,
    output cpu_pkg::byte_t   o_result,
    output logic             o_carry,
    output logic             o_overflow
);

    logic [`CPU_DATA_W:0] sum;

    // Binary add only, no decimal mode
    assign sum = {1'b0, i_a} + {1'b0, i_b} + {{`CPU_DATA_W{1'b0}}, i_carry};

    always_comb begin
        case (i_op)
            cpu_pkg::ALU_ADC:  o_result = sum[`CPU_DATA_W-1:0];
            cpu_pkg::ALU_AND:  o_result = i_a & i_b;
            cpu_pkg::ALU_ORA:  o_result = i_a | i_b;
            cpu_pkg::ALU_EOR:  o_result = i_a ^ i_b;
            cpu_pkg::ALU_INC:  o_result = i_b + 8'd1;
            cpu_pkg::ALU_XFER: o_result = i_a;
            default:           o_result = i_b;
        endcase
    end

    assign o_carry = sum[`CPU_DATA_W];

    // Same-sign operands giving a result of the other sign
    assign o_overflow = (i_a[`CPU_DATA_W-1] == i_b[`CPU_DATA_W-1]) &&
                        (sum[`CPU_DATA_W-1] != i_a[`CPU_DATA_W-1]);

endmodule

/* cpu_pc.sv */
`timescale 1ns/1ns
`include "cpu_config.svh"

module cpu_pc (
    input  logic           i_clk,
    input  logic           i_rst_n,
    input  cpu_pkg::ctrl_t i_ctrl,
    input  cpu_pkg::byte_t i_target_lo,
    input  cpu_pkg::byte_t i_data,
    output cpu_pkg::addr_t o_pc
);

    cpu_pkg::addr_t pc;

    // Jump load wins over increment
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            pc <= `CPU_RESET_PC;
        end else if (i_ctrl.pc_load) begin
            pc <= {i_data, i_target_lo};
        end else if (i_ctrl.pc_inc) begin
            pc <= pc + 16'd1;
        end
    end

    assign o_pc = pc;

endmodule

/* cpu_decoder.sv */
`timescale 1ns/1ns

module cpu_decoder (
    input  logic           i_clk,
    input  logic           i_rst_n,
    input  cpu_pkg::byte_t i_data,
    output cpu_pkg::ctrl_t o_ctrl,
    output logic           o_sync,
    output logic           o_error
);

    // Supported opcodes, original 6502 encodings
    localparam cpu_pkg::byte_t OP_LDA_IMM = 8'hA9;
    localparam cpu_pkg::byte_t OP_LDX_IMM = 8'hA2;
    localparam cpu_pkg::byte_t OP_ADC_IMM = 8'h69;
    localparam cpu_pkg::byte_t OP_AND_IMM = 8'h29;
    localparam cpu_pkg::byte_t OP_ORA_IMM = 8'h09;
    localparam cpu_pkg::byte_t OP_EOR_IMM = 8'h49;
    localparam cpu_pkg::byte_t OP_STA_ABS = 8'h8D;
    localparam cpu_pkg::byte_t OP_JMP_ABS = 8'h4C;
    localparam cpu_pkg::byte_t OP_TAX     = 8'hAA;
    localparam cpu_pkg::byte_t OP_INX     = 8'hE8;
    localparam cpu_pkg::byte_t OP_CLC     = 8'h18;
    localparam cpu_pkg::byte_t OP_SEC     = 8'h38;

    cpu_pkg::tcu_t  state;
    cpu_pkg::tcu_t  state_nxt;
    cpu_pkg::byte_t ir;
    cpu_pkg::byte_t opcode;
    cpu_pkg::ctrl_t exec;
    logic           op_known;
    logic           op_long;
    logic           op_sta;

    // During T0 the opcode is still on the bus, IR not yet loaded
    assign opcode = (state == cpu_pkg::T0) ? i_data : ir;

    // T1 control word per opcode
    always_comb begin
        exec          = '0;
        exec.rw       = 1'b1;
        exec.addr_src = cpu_pkg::ADDR_PC;
        exec.alu_op   = cpu_pkg::ALU_PASS;
        op_known      = 1'b1;
        op_long       = 1'b0;
        op_sta        = 1'b0;
        case (opcode)
            OP_LDA_IMM, OP_AND_IMM, OP_ORA_IMM, OP_EOR_IMM, OP_ADC_IMM: begin
                exec.pc_inc = 1'b1;
                exec.ld_ac  = 1'b1;
                exec.set_nz = 1'b1;
                if (opcode == OP_AND_IMM) begin
                    exec.alu_op = cpu_pkg::ALU_AND;
                end else if (opcode == OP_ORA_IMM) begin
                    exec.alu_op = cpu_pkg::ALU_ORA;
                end else if (opcode == OP_EOR_IMM) begin
                    exec.alu_op = cpu_pkg::ALU_EOR;
                end else if (opcode == OP_ADC_IMM) begin
                    exec.alu_op = cpu_pkg::ALU_ADC;
                    exec.set_cv = 1'b1;
                end
            end
            OP_LDX_IMM: begin
                exec.pc_inc = 1'b1;
                exec.ld_x   = 1'b1;
                exec.set_nz = 1'b1;
            end
            OP_TAX: begin
                exec.alu_op = cpu_pkg::ALU_XFER;
                exec.ld_x   = 1'b1;
                exec.set_nz = 1'b1;
            end
            OP_INX: begin
                exec.src_x  = 1'b1;
                exec.alu_op = cpu_pkg::ALU_INC;
                exec.ld_x   = 1'b1;
                exec.set_nz = 1'b1;
            end
            OP_CLC: exec.clr_c = 1'b1;
            OP_SEC: exec.set_c = 1'b1;
            OP_STA_ABS, OP_JMP_ABS: begin
                // Low address byte follows the opcode
                exec.pc_inc = 1'b1;
                exec.lat_lo = 1'b1;
                op_long     = 1'b1;
                op_sta      = (opcode == OP_STA_ABS);
            end
            default: op_known = 1'b0;
        endcase
    end

    always_comb begin
        o_ctrl          = '0;
        o_ctrl.rw       = 1'b1;
        o_ctrl.addr_src = cpu_pkg::ADDR_PC;
        o_ctrl.alu_op   = cpu_pkg::ALU_PASS;
        state_nxt       = state;
        case (state)
            cpu_pkg::T0: begin
                o_ctrl.sync   = 1'b1;
                o_ctrl.pc_inc = 1'b1;
                state_nxt     = op_known ? cpu_pkg::T1 : cpu_pkg::HALT;
            end
            cpu_pkg::T1: begin
                o_ctrl    = exec;
                state_nxt = op_long ? cpu_pkg::T2 : cpu_pkg::T0;
            end
            cpu_pkg::T2: begin
                if (op_sta) begin
                    o_ctrl.pc_inc = 1'b1;
                    o_ctrl.lat_hi = 1'b1;
                    state_nxt     = cpu_pkg::T3;
                end else begin
                    // JMP takes its high byte straight off the bus
                    o_ctrl.pc_load = 1'b1;
                    state_nxt      = cpu_pkg::T0;
                end
            end
            cpu_pkg::T3: begin
                o_ctrl.rw       = 1'b0;
                o_ctrl.addr_src = cpu_pkg::ADDR_ABS;
                state_nxt       = cpu_pkg::T0;
            end
            default: state_nxt = cpu_pkg::HALT;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state <= cpu_pkg::T0;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == cpu_pkg::T0) begin
            ir <= i_data;
        end
    end

    assign o_sync  = o_ctrl.sync;
    assign o_error = (state == cpu_pkg::HALT);

endmodule

/* cpu_datapath.sv */
`timescale 1ns/1ns

module cpu_datapath (
    input  logic            i_clk,
    input  logic            i_rst_n,
    input  cpu_pkg::ctrl_t  i_ctrl,
    input  cpu_pkg::byte_t  i_data,
    input  cpu_pkg::addr_t  i_pc,
    output cpu_pkg::addr_t  o_address,
    output cpu_pkg::byte_t  o_data,
    output logic            o_rw,
    output cpu_pkg::byte_t  o_abs_lo,
    output cpu_pkg::status_t o_flags,
    output cpu_pkg::byte_t  o_ac,
    output cpu_pkg::byte_t  o_x
);

    cpu_pkg::byte_t   ac;
    cpu_pkg::byte_t   x;
    cpu_pkg::status_t flags;
    cpu_pkg::byte_t   abs_lo;
    cpu_pkg::byte_t   abs_hi;
    cpu_pkg::byte_t   alu_b;
    cpu_pkg::byte_t   alu_res;
    logic             alu_carry;
    logic             alu_ovf;

    // Operand B is the bus byte unless X is asked for
    assign alu_b = i_ctrl.src_x ? x : i_data;

    cpu_alu u_cpu_alu (
        .i_a        (ac),
        .i_b        (alu_b),
        .i_carry    (flags.c),
        .i_op       (i_ctrl.alu_op),
        .o_result   (alu_res),
        .o_carry    (alu_carry),
        .o_overflow (alu_ovf)
    );

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            ac    <= '0;
            x     <= '0;
            flags <= '0;
        end else begin
            if (i_ctrl.ld_ac) begin
                ac <= alu_res;
            end
            if (i_ctrl.ld_x) begin
                x <= alu_res;
            end
            if (i_ctrl.set_nz) begin
                flags.n <= alu_res[7];
                flags.z <= (alu_res == 8'd0);
            end
            if (i_ctrl.set_cv) begin
                flags.c <= alu_carry;
                flags.v <= alu_ovf;
            end
            if (i_ctrl.clr_c) begin
                flags.c <= 1'b0;
            end
            if (i_ctrl.set_c) begin
                flags.c <= 1'b1;
            end
        end
    end

    // Absolute operand bytes, low first
    always_ff @(posedge i_clk) begin
        if (i_ctrl.lat_lo) begin
            abs_lo <= i_data;
        end
        if (i_ctrl.lat_hi) begin
            abs_hi <= i_data;
        end
    end

    assign o_address = (i_ctrl.addr_src == cpu_pkg::ADDR_ABS) ? {abs_hi, abs_lo} : i_pc;
    assign o_data    = ac;
    assign o_rw      = i_ctrl.rw;
    assign o_abs_lo  = abs_lo;
    assign o_flags   = flags;
    assign o_ac      = ac;
    assign o_x       = x;

endmodule

/* cpu_core.sv */
`timescale 1ns/1ns

module cpu_core (
    input  logic           i_clk,
    input  logic           i_rst_n,
    input  cpu_pkg::byte_t i_data,
    output logic           o_rw,
    output cpu_pkg::addr_t o_address,
    output cpu_pkg::byte_t o_data,
    output logic           o_sync,
    output logic           o_error,
    output cpu_pkg::byte_t o_debug_ac,
    output cpu_pkg::byte_t o_debug_x,
    output cpu_pkg::byte_t o_debug_p,
    output cpu_pkg::addr_t o_debug_pc
);

    cpu_pkg::ctrl_t   ctrl;
    cpu_pkg::status_t flags;
    cpu_pkg::addr_t   pc;
    cpu_pkg::byte_t   abs_lo;

    cpu_decoder u_cpu_decoder (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_data  (i_data),
        .o_ctrl  (ctrl),
        .o_sync  (o_sync),
        .o_error (o_error)
    );

    cpu_pc u_cpu_pc (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_ctrl      (ctrl),
        .i_target_lo (abs_lo),
        .i_data      (i_data),
        .o_pc        (pc)
    );

    cpu_datapath u_cpu_datapath (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_ctrl    (ctrl),
        .i_data    (i_data),
        .i_pc      (pc),
        .o_address (o_address),
        .o_data    (o_data),
        .o_rw      (o_rw),
        .o_abs_lo  (abs_lo),
        .o_flags   (flags),
        .o_ac      (o_debug_ac),
        .o_x       (o_debug_x)
    );

    // NV----ZC, unused bits read zero
    assign o_debug_p  = {flags.n, flags.v, 4'b0000, flags.z, flags.c};
    assign o_debug_pc = pc;

endmodule

/* cpu_chk.sv */
`timescale 1ns/1ns

module cpu_chk (
    input logic i_clk,
    input logic i_rst_n,
    input logic i_rw,
    input logic i_sync,
    input logic i_error
);

    // No write during an opcode fetch
    a_sync_read: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_sync |-> i_rw)
        else $error("write cycle during sync");

    // Every instruction takes at least two cycles
    // Sync stays high while reset is held
    a_sync_single: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_rst_n && i_sync) |=> !i_sync)
        else $error("sync high in two consecutive cycles");

    a_error_sticky: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_error |=> i_error)
        else $error("error dropped without reset");

    a_halt_read: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_error |-> i_rw)
        else $error("write cycle while halted");

endmodule

bind cpu_core cpu_chk u_cpu_chk (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_rw    (o_rw),
    .i_sync  (o_sync),
    .i_error (o_error)
);

/* tb_cpu.sv */
`timescale 1ns/1ns
`include "cpu_config.svh"

module tb_cpu;

    localparam int  CLK_PERIOD = 20;
    localparam int  MAX_CYCLES = 200;
    localparam int  WATCHDOG_NS = 5 * MAX_CYCLES * 2 * CLK_PERIOD;

    logic           clk = 1'b0;
    logic           rst_n;
    cpu_pkg::byte_t rd_data;
    logic           rw;
    cpu_pkg::addr_t address;
    cpu_pkg::byte_t wr_data;
    logic           sync;
    logic           error;
    cpu_pkg::byte_t dbg_ac;
    cpu_pkg::byte_t dbg_x;
    cpu_pkg::byte_t dbg_p;
    cpu_pkg::addr_t dbg_pc;

    cpu_pkg::byte_t mem [0:65535];
    cpu_pkg::addr_t log_addr [$];
    cpu_pkg::byte_t log_data [$];
    cpu_pkg::addr_t sync_q [$];
    cpu_pkg::addr_t wp;
    int             errors = 0;
    int             pass_cnt = 0;
    int             fail_cnt = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    cpu_core u_cpu_core (
        .i_clk      (clk),
        .i_rst_n    (rst_n),
        .i_data     (rd_data),
        .o_rw       (rw),
        .o_address  (address),
        .o_data     (wr_data),
        .o_sync     (sync),
        .o_error    (error),
        .o_debug_ac (dbg_ac),
        .o_debug_x  (dbg_x),
        .o_debug_p  (dbg_p),
        .o_debug_pc (dbg_pc)
    );

    // Memory with combinational read, write on the clock edge
    assign rd_data = mem[address];

    always @(posedge clk) begin
        if (rst_n && !rw) begin
            mem[address] <= wr_data;
            log_addr.push_back(address);
            log_data.push_back(wr_data);
        end
    end

    task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic clear_mem();
        for (int a = 0; a < 65536; a++) begin
            mem[a[15:0]] = a[15:8] ^ a[7:0] ^ 8'hA5;
        end
        wp = `CPU_RESET_PC;
    endtask

    task automatic emit(input cpu_pkg::byte_t b);
        mem[wp] = b;
        wp++;
    endtask

    task automatic emit_imm(input cpu_pkg::byte_t op, input cpu_pkg::byte_t val);
        emit(op);
        emit(val);
    endtask

    task automatic emit_abs(input cpu_pkg::byte_t op, input cpu_pkg::addr_t a);
        emit(op);
        emit(a[7:0]);
        emit(a[15:8]);
    endtask

    task automatic reset_core();
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        log_addr.delete();
        log_data.delete();
        sync_q.delete();
    endtask

    // Waits for n more opcode fetches, or until the core halts
    task automatic run_syncs(input int n);
        int seen;
        seen = 0;
        while (seen < n && !error) begin
            @(negedge clk);
            if (sync) begin
                seen++;
                sync_q.push_back(address);
            end
        end
    endtask

    task automatic check_nz(input string what, input cpu_pkg::byte_t v);
        check_eq({what, " N"}, 32'(dbg_p[7]), 32'(v[7]));
        check_eq({what, " Z"}, 32'(dbg_p[1]), 32'(v == 8'd0));
    endtask

    task automatic check_adc(input cpu_pkg::byte_t a, input cpu_pkg::byte_t b, input logic cin);
        logic [8:0] sum;
        sum = 9'(a) + 9'(b) + 9'(cin);
        check_eq("ADC carry", 32'(dbg_p[0]), 32'(sum[8]));
        check_eq("ADC overflow", 32'(dbg_p[6]), 32'((a[7] == b[7]) && (sum[7] != a[7])));
    endtask

    task automatic report(input string name, input int err_before);
        if (errors == err_before) begin
            pass_cnt++;
            $display("test %s: ok", name);
        end else begin
            fail_cnt++;
            $display("test %s: %0d errors", name, errors - err_before);
        end
    endtask

    task automatic test_load_store();
        cpu_pkg::byte_t v1;
        cpu_pkg::byte_t v2;
        int             e0;
        e0 = errors;
        v1 = 8'($urandom);
        v2 = 8'($urandom);
        clear_mem();
        emit_imm(8'hA9, v1);
        emit(8'hAA);
        emit(8'hE8);
        emit_abs(8'h8D, 16'h0300);
        emit_imm(8'hA2, v2);
        emit(8'hE8);
        emit(8'hAA);
        emit_abs(8'h8D, 16'h0301);
        emit_abs(8'h4C, wp);
        reset_core();
        run_syncs(7);
        check_eq("AC after LDA", 32'(dbg_ac), 32'(v1));
        check_eq("X after LDX INX", 32'(dbg_x), 32'(8'(v2 + 8'd1)));
        run_syncs(2);
        check_eq("write count", log_addr.size(), 2);
        check_eq("mem 0300", 32'(mem[16'h0300]), 32'(v1));
        check_eq("mem 0301", 32'(mem[16'h0301]), 32'(v1));
        check_eq("X after TAX", 32'(dbg_x), 32'(v1));
        report("load_store", e0);
    endtask

    task automatic test_adc();
        cpu_pkg::byte_t a;
        cpu_pkg::byte_t b;
        cpu_pkg::byte_t c;
        cpu_pkg::byte_t d;
        int             e0;
        e0 = errors;
        a = 8'($urandom);
        b = 8'($urandom);
        c = 8'($urandom);
        d = 8'($urandom);
        clear_mem();
        // Carry is set before CLC and cleared before SEC
        emit(8'h38);
        emit(8'h18);
        emit_imm(8'hA9, a);
        emit_imm(8'h69, b);
        emit_abs(8'h8D, 16'h0310);
        emit(8'h18);
        emit(8'h38);
        emit_imm(8'hA9, c);
        emit_imm(8'h69, d);
        emit_abs(8'h8D, 16'h0311);
        emit_abs(8'h4C, wp);
        reset_core();
        run_syncs(5);
        check_adc(a, b, 1'b0);
        run_syncs(5);
        check_adc(c, d, 1'b1);
        run_syncs(1);
        check_eq("mem 0310", 32'(mem[16'h0310]), 32'(8'(a + b)));
        check_eq("mem 0311", 32'(mem[16'h0311]), 32'(8'(c + d + 8'd1)));
        report("adc", e0);
    endtask

    task automatic test_logic();
        cpu_pkg::byte_t a;
        cpu_pkg::byte_t b;
        int             e0;
        e0 = errors;
        a = 8'($urandom);
        b = 8'($urandom);
        clear_mem();
        emit_imm(8'hA9, a);
        emit_imm(8'h29, b);
        emit_abs(8'h8D, 16'h0320);
        emit_imm(8'hA9, a);
        emit_imm(8'h09, b);
        emit_abs(8'h8D, 16'h0321);
        // EOR with itself forces a zero result
        emit_imm(8'hA9, a);
        emit_imm(8'h49, a);
        emit_abs(8'h8D, 16'h0322);
        emit_abs(8'h4C, wp);
        reset_core();
        run_syncs(3);
        check_nz("AND", a & b);
        run_syncs(3);
        check_nz("ORA", a | b);
        run_syncs(3);
        check_nz("EOR", 8'd0);
        run_syncs(1);
        check_eq("mem 0320", 32'(mem[16'h0320]), 32'(a & b));
        check_eq("mem 0321", 32'(mem[16'h0321]), 32'(a | b));
        check_eq("mem 0322", 32'(mem[16'h0322]), 0);
        report("logic", e0);
    endtask

    task automatic test_jmp();
        int e0;
        e0 = errors;
        clear_mem();
        emit_abs(8'h4C, 16'h0208);
        emit_abs(8'h8D, 16'h03FF);
        wp = 16'h0208;
        emit_imm(8'hA9, 8'h5A);
        emit_abs(8'h8D, 16'h0330);
        emit_abs(8'h4C, 16'h020D);
        reset_core();
        run_syncs(4);
        check_eq("sync count", sync_q.size(), 4);
        check_eq("sync 0", 32'(sync_q[0]), 32'h0200);
        check_eq("sync 1", 32'(sync_q[1]), 32'h0208);
        check_eq("sync 2", 32'(sync_q[2]), 32'h020A);
        check_eq("sync 3", 32'(sync_q[3]), 32'h020D);
        check_eq("write count", log_addr.size(), 1);
        check_eq("write address", 32'(log_addr[0]), 32'h0330);
        check_eq("write data", 32'(log_data[0]), 32'h5A);
        report("jmp", e0);
    endtask

    task automatic test_bad_opcode();
        int e0;
        int n_wr;
        int extra_sync;
        e0 = errors;
        extra_sync = 0;
        clear_mem();
        emit_imm(8'hA9, 8'h11);
        emit(8'h02);
        reset_core();
        run_syncs(10);
        check_eq("error raised", 32'(error), 1);
        check_eq("syncs before halt", sync_q.size(), 2);
        n_wr = log_addr.size();
        repeat (20) begin
            @(negedge clk);
            if (sync) begin
                extra_sync++;
            end
        end
        check_eq("syncs while halted", extra_sync, 0);
        check_eq("writes while halted", log_addr.size(), n_wr);
        // PC stays just past the bad opcode
        check_eq("PC while halted", 32'(dbg_pc), 32'h0203);
        reset_core();
        run_syncs(1);
        check_eq("error after reset", 32'(error), 0);
        check_eq("restart address", 32'(sync_q[0]), 32'(`CPU_RESET_PC));
        check_eq("restart PC", 32'(dbg_pc), 32'(`CPU_RESET_PC));
        report("bad_opcode", e0);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired, the core stopped making progress");
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        int seed;
        rst_n = 1'b0;
        seed = $urandom(37627);
        clear_mem();
        test_load_store();
        test_adc();
        test_logic();
        test_jmp();
        test_bad_opcode();
        $display("tests ok %0d, failed %0d, errors %0d", pass_cnt, fail_cnt, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* src.f */
+incdir+.
cpu_pkg.sv
cpu_alu.sv
cpu_pc.sv
cpu_decoder.sv
cpu_datapath.sv
cpu_core.sv
cpu_chk.sv
tb_cpu.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_cpu
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
FLIST     ?= src.f

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) --binary --timing --assert -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q '\*\*\* TEST FAILED \*\*\*' $(LOG); then \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
